/* Makefile */
VERILATOR = verilator
TOP       = fp16_mul_tb
FILELIST  = fp16_mul_top.f
VFLAGS    = --binary --timing --assert --top-module $(TOP)
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard logic/*.sv verification/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* fp16_mul_top.f */
logic/fp16_pkg.sv
logic/booth_pkg.sv
logic/prefix_adder.sv
logic/operand_stage.sv
logic/booth_encoder.sv
logic/wallace_reducer.sv
logic/result_stage.sv
logic/fp16_mul_top.sv
verification/fp16_mul_checker.sv
verification/fp16_mul_tb.sv

/* logic/booth_encoder.sv */
/*
 * Radix-4 Booth encoder
 * Recodes the multiplier into six shifted partial products
 */

module booth_encoder import booth_pkg::*; (
  input  sig_t  multiplicand,
  input  sig_t  multiplier,
  output prod_t pp [NUM_PP]
);

  localparam int SIG_W = $bits(sig_t);

  prod_t mcand_pos1;
  prod_t mcand_neg1;
  prod_t mcand_pos2;
  prod_t mcand_neg2;

  // Multiplier with the implicit zero below bit 0
  logic [SIG_W:0] mplier_ext;

  assign mcand_pos1 = {{(PROD_WIDTH - SIG_W){multiplicand[SIG_W-1]}}, multiplicand};

  // Two's complement negation as inversion plus one
  prefix_adder #(
    .WIDTH(PROD_WIDTH)
  ) negate_i (
    .x   (~mcand_pos1),
    .y   ('0),
    .cin (1'b1),
    .sum (mcand_neg1)
  );

  assign mcand_pos2 = mcand_pos1 << 1;
  assign mcand_neg2 = mcand_neg1 << 1;

  assign mplier_ext = {multiplier, 1'b0};

  for (genvar k = 0; k < NUM_PP; k++) begin : g_pp
    logic [2:0] window;
    prod_t      multiple;

    // Overlapping window b(2k+1), b(2k), b(2k-1)
    assign window = mplier_ext[2*k+2 -: 3];

    always_comb begin
      case (window)
        3'b001, 3'b010: multiple = mcand_pos1;
        3'b011:         multiple = mcand_pos2;
        3'b100:         multiple = mcand_neg2;
        3'b101, 3'b110: multiple = mcand_neg1;
        default:        multiple = '0;
      endcase
    end

    assign pp[k] = multiple << (2 * k);
  end

endmodule

/* logic/booth_pkg.sv */
/*
 * Booth significand multiplier
 * Widths and partial product count of the radix-4 datapath
 */

package booth_pkg;

  localparam int PROD_WIDTH = 24;

  // One partial product per pair of multiplier bits
  localparam int NUM_PP = 6;

  // Two top bits, hidden bit second, then the fraction
  typedef logic [11:0] sig_t;

  // Sign-extended partial product or full product
  typedef logic [PROD_WIDTH-1:0] prod_t;

endpackage

/* logic/fp16_mul_top.sv */
/*
 * Half-precision multiplier top level
 * Operand registers, Booth significand multiplier and result registers
 */

module fp16_mul_top import fp16_pkg::*, booth_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  fp16_t a,
  input  fp16_t b,
  output fp16_t result
);

  logic  sign_a;
  logic  sign_b;
  exp_t  exp_a;
  exp_t  exp_b;
  sig_t  sig_a;
  sig_t  sig_b;
  prod_t pp [NUM_PP];
  prod_t product;

  operand_stage operand_stage_i (
    .clk    (clk),
    .rst    (rst),
    .a      (a),
    .b      (b),
    .sign_a (sign_a),
    .sign_b (sign_b),
    .exp_a  (exp_a),
    .exp_b  (exp_b),
    .sig_a  (sig_a),
    .sig_b  (sig_b)
  );

  // Significand multiplier, purely combinational
  booth_encoder booth_encoder_i (
    .multiplicand (sig_a),
    .multiplier   (sig_b),
    .pp           (pp)
  );

  wallace_reducer wallace_reducer_i (
    .pp      (pp),
    .product (product)
  );

  result_stage result_stage_i (
    .clk     (clk),
    .rst     (rst),
    .product (product),
    .sign_a  (sign_a),
    .sign_b  (sign_b),
    .exp_a   (exp_a),
    .exp_b   (exp_b),
    .result  (result)
  );

endmodule

/* logic/fp16_pkg.sv */
/*
 * Half-precision (binary16) number format
 * Field widths of the IEEE word and its exponent bias
 */

package fp16_pkg;

  // Whole word: sign, exponent, fraction
  typedef logic [15:0] fp16_t;

  // Biased exponent field
  typedef logic [4:0] exp_t;

  // Stored fraction, hidden bit not included
  typedef logic [9:0] frac_t;

  localparam int EXP_BIAS = 15;

endpackage

/* logic/operand_stage.sv */
/*
 * Operand stage
 * Registers both operands and forms their significands
 */

module operand_stage import fp16_pkg::*, booth_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  fp16_t a,
  input  fp16_t b,
  output logic  sign_a,
  output logic  sign_b,
  output exp_t  exp_a,
  output exp_t  exp_b,
  output sig_t  sig_a,
  output sig_t  sig_b
);

  frac_t frac_a;
  frac_t frac_b;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
      exp_a  <= '0;
      exp_b  <= '0;
      frac_a <= '0;
      frac_b <= '0;
    end else begin
      sign_a <= a[15];
      sign_b <= b[15];
      exp_a  <= a[14:10];
      exp_b  <= b[14:10];
      frac_a <= a[9:0];
      frac_b <= b[9:0];
    end
  end

  // Hidden bit only for a nonzero exponent
  assign sig_a = {1'b0, |exp_a, frac_a};
  assign sig_b = {1'b0, |exp_b, frac_b};

endmodule

/* logic/prefix_adder.sv */
/*
 * Kogge-Stone parallel-prefix adder
 * Any width, carry-in folded in below bit 0, no carry-out
 */

module prefix_adder #(
  parameter int WIDTH = 24
) (
  input  logic [WIDTH-1:0] x,
  input  logic [WIDTH-1:0] y,
  input  logic             cin,
  output logic [WIDTH-1:0] sum
);

  localparam int LEVELS = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  logic [WIDTH-1:0] prop;

  // Index i of a level holds the group ending at bit i-1, index 0 is cin
  logic [WIDTH-1:0] gen_lvl  [LEVELS+1];
  logic [WIDTH-1:0] prop_lvl [LEVELS];

  assign prop = x ^ y;

  assign gen_lvl[0][0]  = cin;
  assign prop_lvl[0][0] = 1'b0;

  for (genvar i = 1; i < WIDTH; i++) begin : g_init
    assign gen_lvl[0][i]  = x[i-1] & y[i-1];
    assign prop_lvl[0][i] = prop[i-1];
  end

  //////////////////////////////////////////////////////////////////////
  // Prefix levels, span doubles each level
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    localparam int D = 1 << l;

    for (genvar i = 0; i < WIDTH; i++) begin : g_node
      if (i >= D) begin : g_cell
        assign gen_lvl[l+1][i] = gen_lvl[l][i] | (prop_lvl[l][i] & gen_lvl[l][i-D]);
        if (l + 1 < LEVELS) begin : g_prop
          assign prop_lvl[l+1][i] = prop_lvl[l][i] & prop_lvl[l][i-D];
        end
      end else begin : g_pass
        assign gen_lvl[l+1][i] = gen_lvl[l][i];
        if (l + 1 < LEVELS) begin : g_prop
          assign prop_lvl[l+1][i] = prop_lvl[l][i];
        end
      end
    end
  end

  // Final generate at index i is the carry into bit i
  for (genvar i = 0; i < WIDTH; i++) begin : g_sum
    assign sum[i] = prop[i] ^ gen_lvl[LEVELS][i];
  end

endmodule

/* logic/result_stage.sv */
/*
 * Result stage
 * Registers the product with signs and exponents, then
 * normalizes by one bit, truncates and rebiases the exponent
 */

module result_stage import fp16_pkg::*, booth_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  prod_t product,
  input  logic  sign_a,
  input  logic  sign_b,
  input  exp_t  exp_a,
  input  exp_t  exp_b,
  output fp16_t result
);

  logic [21:0] prod_q;
  logic        sign_a_q;
  logic        sign_b_q;
  exp_t        exp_a_q;
  exp_t        exp_b_q;

  logic        norm;
  frac_t       res_frac;
  exp_t        res_exp;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prod_q   <= '0;
      sign_a_q <= 1'b0;
      sign_b_q <= 1'b0;
      exp_a_q  <= '0;
      exp_b_q  <= '0;
    end else begin
      prod_q   <= product[21:0];
      sign_a_q <= sign_a;
      sign_b_q <= sign_b;
      exp_a_q  <= exp_a;
      exp_b_q  <= exp_b;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Normalize and pack
  //////////////////////////////////////////////////////////////////////

  // Product of two or more
  assign norm = prod_q[21];

  assign res_frac = norm ? prod_q[20:11] : prod_q[19:10];

  // Wraps modulo 32, no overflow or underflow handling
  assign res_exp = exp_t'(exp_a_q + exp_b_q + norm - EXP_BIAS);

  assign result = {sign_a_q ^ sign_b_q, res_exp, res_frac};

endmodule

/* logic/wallace_reducer.sv */
/*
 * Wallace reduction tree
 * Three carry-save levels take six partial products to two,
 * then a prefix adder forms the product
 */

module wallace_reducer import booth_pkg::*; (
  input  prod_t pp [NUM_PP],
  output prod_t product
);

  function automatic logic maj3(input logic a, input logic b, input logic c);
    return (a & b) | (a & c) | (b & c);
  endfunction

  prod_t s1a, c1a, s1b, c1b;
  prod_t s2, c2;
  prod_t s3, c3;
  prod_t c1a_sh, c1b_sh, c2_sh, c3_sh;

  // Carries weigh one bit more than the sums they came with
  assign c1a_sh = c1a << 1;
  assign c1b_sh = c1b << 1;
  assign c2_sh  = c2 << 1;
  assign c3_sh  = c3 << 1;

  //////////////////////////////////////////////////////////////////////
  // Carry-save levels, one full adder per bit and CSA
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PROD_WIDTH; i++) begin : g_bit
    // Level 1, two CSAs side by side
    assign s1a[i] = pp[0][i] ^ pp[1][i] ^ pp[2][i];
    assign c1a[i] = maj3(pp[0][i], pp[1][i], pp[2][i]);
    assign s1b[i] = pp[3][i] ^ pp[4][i] ^ pp[5][i];
    assign c1b[i] = maj3(pp[3][i], pp[4][i], pp[5][i]);

    // Level 2
    assign s2[i] = s1a[i] ^ c1a_sh[i] ^ s1b[i];
    assign c2[i] = maj3(s1a[i], c1a_sh[i], s1b[i]);

    // Level 3 picks up the second carry of level 1
    assign s3[i] = s2[i] ^ c2_sh[i] ^ c1b_sh[i];
    assign c3[i] = maj3(s2[i], c2_sh[i], c1b_sh[i]);
  end

  prefix_adder #(
    .WIDTH(PROD_WIDTH)
  ) final_add_i (
    .x   (s3),
    .y   (c3_sh),
    .cin (1'b0),
    .sum (product)
  );

endmodule

/* verification/fp16_mul_checker.sv */
/*
 * Sign and exponent assertions on the multiplier top level
 */

module fp16_mul_checker import fp16_pkg::*; (
  input logic  clk,
  input logic  rst,
  input fp16_t a,
  input fp16_t b,
  input fp16_t result
);

  fp16_t      a_d1, a_d2;
  fp16_t      b_d1, b_d2;
  logic [1:0] warm;
  exp_t       exp_lo;
  exp_t       exp_hi;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      a_d1 <= '0;
      a_d2 <= '0;
      b_d1 <= '0;
      b_d2 <= '0;
      warm <= '0;
    end else begin
      a_d1 <= a;
      a_d2 <= a_d1;
      b_d1 <= b;
      b_d2 <= b_d1;
      if (warm != 2'd2) warm <= warm + 2'd1;
    end
  end

  // Normalize flag clear or set
  assign exp_lo = exp_t'(a_d2[14:10] + b_d2[14:10] - EXP_BIAS);
  assign exp_hi = exp_t'(a_d2[14:10] + b_d2[14:10] - EXP_BIAS + 1);

  sign_rule_a: assert property (@(posedge clk) disable iff (rst || warm != 2'd2)
    result[15] == (a_d2[15] ^ b_d2[15]))
    else $error("Result sign is not the XOR of the operand signs");

  exp_rule_a: assert property (@(posedge clk) disable iff (rst || warm != 2'd2)
    (result[14:10] == exp_lo) || (result[14:10] == exp_hi))
    else $error("Result exponent breaks the exponent rule");

endmodule

bind fp16_mul_top fp16_mul_checker checker_i (
  .clk    (clk),
  .rst    (rst),
  .a      (a),
  .b      (b),
  .result (result)
);

/* verification/fp16_mul_tb.sv */
/*
 * Testbench for the half-precision multiplier
 * Directed and random operand pairs checked against a reference model
 */

module fp16_mul_tb import fp16_pkg::*; ();

  localparam int RESET_CYCLES = 3;
  localparam int NUM_RANDOM   = 200;
  // Directed cycles with pipeline drains, rounded up
  localparam int NUM_DIRECTED = 40;
  localparam int TIMEOUT = (RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 20) * 100;

  logic   clk;
  logic   rst;
  fp16_t  a;
  fp16_t  b;
  fp16_t  result;
  integer seed = 21;

  // Expected results in flight, one entry per driven cycle
  fp16_t  expect_q [$];
  bit     valid_q [$];

  fp16_mul_top dut_i (
    .clk    (clk),
    .rst    (rst),
    .a      (a),
    .b      (b),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic fp16_t model_multiply(input fp16_t x, input fp16_t y);
    logic [21:0] sig_x;
    logic [21:0] sig_y;
    logic [21:0] prod;
    logic        norm;
    sig_x = {11'd0, x[14:10] != 5'd0, x[9:0]};
    sig_y = {11'd0, y[14:10] != 5'd0, y[9:0]};
    prod  = sig_x * sig_y;
    norm  = prod[21];
    return {x[15] ^ y[15], exp_t'(x[14:10] + y[14:10] + norm - EXP_BIAS),
            norm ? prod[20:11] : prod[19:10]};
  endfunction

  task automatic check_result(input fp16_t actual, input fp16_t expected);
    if (actual !== expected) begin
      $display("Fail at time %0t: result %h, expected %h", $time, actual, expected);
      $display("Checks failed");
      $fatal(1, "Result mismatch");
    end
  endtask

  // One clock of stimulus, result checked two cycles after its operands
  task automatic drive_vector(input bit valid, input fp16_t op_a, input fp16_t op_b,
                              input fp16_t want);
    fp16_t due;
    bit    due_valid;
    @(negedge clk);
    if (valid_q.size() == 2) begin
      due       = expect_q.pop_front();
      due_valid = valid_q.pop_front();
      if (due_valid) check_result(result, due);
    end
    a = op_a;
    b = op_b;
    expect_q.push_back(want);
    valid_q.push_back(valid);
  endtask

  task automatic apply_pair(input fp16_t op_a, input fp16_t op_b);
    drive_vector(1'b1, op_a, op_b, model_multiply(op_a, op_b));
  endtask

  task automatic drain_pipeline();
    repeat (2) drive_vector(1'b0, a, b, '0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // Operands held through reset have not reached the output yet
  task automatic test_reset_value();
    check_result(result, 16'h4400);
    @(negedge clk);
    check_result(result, 16'h4400);
  endtask

  task automatic test_no_normalize();
    drive_vector(1'b1, 16'h3E00, 16'h3D00, 16'h3F80);
    // One times a normal value is exact
    drive_vector(1'b1, 16'h3C00, 16'h4248, 16'h4248);
    drive_vector(1'b1, 16'h3C00, 16'h0C01, 16'h0C01);
    drive_vector(1'b1, 16'h7BFF, 16'h3C00, 16'h7BFF);
    apply_pair(16'h4A00, 16'h3400);
    drain_pipeline();
  endtask

  task automatic test_normalize();
    drive_vector(1'b1, 16'h3E00, 16'h3E00, 16'h4080);
    drive_vector(1'b1, 16'h3F00, 16'h3F00, 16'h4220);
    // Low product bits dropped
    drive_vector(1'b1, 16'h3FFF, 16'h3FFF, 16'h43FE);
    apply_pair(16'h4500, 16'h3E66);
    drain_pipeline();
  endtask

  task automatic test_sign_rule();
    for (int s = 0; s < 4; s++) begin
      drive_vector(1'b1, {s[1], 15'h3E00}, {s[0], 15'h4100}, {s[1] ^ s[0], 15'h4380});
    end
    drain_pipeline();
  endtask

  task automatic test_zero_exponent();
    drive_vector(1'b1, 16'h0200, 16'h3C00, 16'h0200);
    drive_vector(1'b1, 16'h0000, 16'h4000, 16'h0400);
    // Exponent 0 + 0 - 15 wraps to 17
    drive_vector(1'b1, 16'h0155, 16'h0155, 16'h4471);
    drive_vector(1'b1, 16'h8001, 16'h7BFF, 16'hBC01);
    drive_vector(1'b1, 16'h03FF, 16'h4400, 16'h0BFF);
    drain_pipeline();
  endtask

  task automatic test_random_stream();
    fp16_t op_a;
    fp16_t op_b;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op_a = fp16_t'($random(seed));
      op_b = fp16_t'($random(seed));
      apply_pair(op_a, op_b);
    end
    drain_pipeline();
  endtask

  initial begin
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    rst = 1'b1;
    a   = 16'h3E00;
    b   = 16'h3E00;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    test_reset_value();
    test_no_normalize();
    test_normalize();
    test_sign_rule();
    test_zero_exponent();
    test_random_stream();
    $display("All checks passed");
    $finish;
  end

endmodule
